// File: run_sim.sh
#!/bin/sh
# build and run the pong ball controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module ball_control_tb \
    -o ball_control_sim

./obj_dir/ball_control_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    exit 1
fi
exit 0

// File: sim.f
+incdir+src
src/pong_pkg.sv
src/ball_fsm.sv
src/ball_direction.sv
src/ball_motion.sv
src/score_keeper.sv
src/ball_control.sv
verification/ball_control_tb.sv

// File: src/ball_control.sv
// pong ball controller top: state machine, direction, motion and score blocks
`timescale 1ns/1ps

module ball_control (
    input  logic                  clk65MHz,
    input  logic                  rst,
    input  logic                  end_of_frame,
    input  logic                  serve,
    input  logic                  screen_idle,
    input  pong_pkg::racket_pos_t pos_of_player_1,
    input  pong_pkg::racket_pos_t pos_of_player_2,
    output pong_pkg::ball_pos_t   ball,
    output pong_pkg::score_t      score,
    output logic [1:0]            who_won
);

    pong_pkg::game_state_t state;
    pong_pkg::flight_dir_t dir;
    logic                  point;
    logic                  miss;
    logic                  at_edge;
    logic                  game_over;

    ball_fsm u_ball_fsm (
        .clk65MHz   (clk65MHz),
        .rst        (rst),
        .serve      (serve),
        .screen_idle(screen_idle),
        .miss       (miss),
        .at_edge    (at_edge),
        .game_over  (game_over),
        .state      (state),
        .point      (point)
    );

    ball_direction u_ball_direction (
        .clk65MHz       (clk65MHz),
        .rst            (rst),
        .state          (state),
        .ball           (ball),
        .pos_of_player_1(pos_of_player_1),
        .pos_of_player_2(pos_of_player_2),
        .dir            (dir),
        .miss           (miss)
    );

    ball_motion u_ball_motion (
        .clk65MHz    (clk65MHz),
        .rst         (rst),
        .state       (state),
        .end_of_frame(end_of_frame),
        .dir         (dir),
        .ball        (ball),
        .at_edge     (at_edge)
    );

    score_keeper u_score_keeper (
        .clk65MHz (clk65MHz),
        .rst      (rst),
        .state    (state),
        .point    (point),
        .dir      (dir),
        .score    (score),
        .game_over(game_over),
        .who_won  (who_won)
    );

endmodule

// File: src/ball_direction.sv
// flight direction register with serve randomizer, wall and racket zone bounces, miss detection
`timescale 1ns/1ps
`include "pong_defines.svh"

module ball_direction (
    input  logic                  clk65MHz,
    input  logic                  rst,
    input  pong_pkg::game_state_t state,
    input  pong_pkg::ball_pos_t   ball,
    input  pong_pkg::racket_pos_t pos_of_player_1,
    input  pong_pkg::racket_pos_t pos_of_player_2,
    output pong_pkg::flight_dir_t dir,
    output logic                  miss
);

    localparam int RIGHT_FACE = `PONG_RIGHT_BOUNCE_X - `PONG_BALL_SIZE;
    localparam int ZONE_UPPER = `PONG_RACKET_LEN / 3;
    localparam int ZONE_MID   = `PONG_RACKET_LEN / 2 + `PONG_BALL_SIZE;

    pong_pkg::flight_dir_t dir_nxt;
    pong_pkg::flight_dir_t bounce_dir;
    logic [6:0]            serve_cnt;
    logic [11:0]           ball_y;
    logic [11:0]           ball_low;
    logic [11:0]           p1_top;
    logic [11:0]           p2_top;
    logic                  heading_east;
    logic                  heading_west;
    logic                  at_right;
    logic                  at_left;
    logic                  right_cover;
    logic                  left_cover;

    // outgoing direction from the racket third that the lower ball edge meets
    function automatic pong_pkg::flight_dir_t zone_bounce(
        input logic [11:0] low_edge,
        input logic [11:0] top,
        input logic        right_side
    );
        pong_pkg::flight_dir_t d;
        d = '0;
        if (low_edge < top + 12'(ZONE_UPPER)) begin
            d.nw = right_side;
            d.ne = !right_side;
        end else if (low_edge < top + 12'(ZONE_MID)) begin
            d.w = right_side;
            d.e = !right_side;
        end else begin
            d.sw = right_side;
            d.se = !right_side;
        end
        return d;
    endfunction

    // flips the vertical part when the ball sits on a wall
    function automatic pong_pkg::flight_dir_t wall_reflect(
        input pong_pkg::flight_dir_t d,
        input logic [10:0]           y
    );
        pong_pkg::flight_dir_t r;
        r = d;
        if (y <= `PONG_WALL_TOP && (d.ne || d.nw)) begin
            r    = '0;
            r.se = d.ne;
            r.sw = d.nw;
        end else if (y >= `PONG_WALL_BOTTOM - `PONG_BALL_SIZE && (d.se || d.sw)) begin
            r    = '0;
            r.ne = d.se;
            r.nw = d.sw;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // racket geometry
    //////////////////////////////////////////////////////////////////////
    assign ball_y       = {1'b0, ball.y};
    assign ball_low     = ball_y + 12'(`PONG_BALL_SIZE);
    assign p1_top       = {2'b00, pos_of_player_1};
    assign p2_top       = {2'b00, pos_of_player_2};
    assign heading_east = dir.ne || dir.e || dir.se;
    assign heading_west = dir.nw || dir.w || dir.sw;
    assign at_right     = ball.x >= RIGHT_FACE;
    assign at_left      = ball.x <= `PONG_LEFT_BOUNCE_X;
    assign right_cover  = ball_low >= p1_top && ball_y <= p1_top + 12'(`PONG_RACKET_LEN);
    assign left_cover   = ball_low >= p2_top && ball_y <= p2_top + 12'(`PONG_RACKET_LEN);

    // only the face the ball is heading for counts
    assign miss = (at_right && heading_east && !right_cover)
               || (at_left && heading_west && !left_cover);

    always_comb begin
        dir_nxt    = dir;
        bounce_dir = dir;
        case (state)
            pong_pkg::IDLE: begin
                dir_nxt = '0;
            end
            pong_pkg::START: begin
                dir_nxt = '0;
                if (serve_cnt <= `PONG_SERVE_T1) begin
                    dir_nxt.sw = 1'b1;
                end else if (serve_cnt <= `PONG_SERVE_T2) begin
                    dir_nxt.nw = 1'b1;
                end else if (serve_cnt <= `PONG_SERVE_T3) begin
                    dir_nxt.w = 1'b1;
                end else if (serve_cnt <= `PONG_SERVE_T4) begin
                    dir_nxt.e = 1'b1;
                end else if (serve_cnt <= `PONG_SERVE_T5) begin
                    dir_nxt.ne = 1'b1;
                end else begin
                    dir_nxt.se = 1'b1;
                end
            end
            pong_pkg::FLY: begin
                // a missed ball keeps its heading for the glide
                if (!miss) begin
                    if (at_right && heading_east) begin
                        bounce_dir = zone_bounce(ball_low, p1_top, 1'b1);
                    end else if (at_left && heading_west) begin
                        bounce_dir = zone_bounce(ball_low, p2_top, 1'b0);
                    end
                    // a racket return close to a wall is turned at once
                    dir_nxt = wall_reflect(bounce_dir, ball.y);
                end
            end
            default: begin
                dir_nxt = dir;
            end
        endcase
    end

    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            dir       <= '0;
            serve_cnt <= '0;
        end else begin
            dir       <= dir_nxt;
            serve_cnt <= serve_cnt + 7'd1;
        end
    end

endmodule

// File: src/ball_fsm.sv
// game state machine: serve, flight, glide after a miss and win sequencing
`timescale 1ns/1ps

module ball_fsm (
    input  logic                  clk65MHz,
    input  logic                  rst,
    input  logic                  serve,
    input  logic                  screen_idle,
    input  logic                  miss,
    input  logic                  at_edge,
    input  logic                  game_over,
    output pong_pkg::game_state_t state,
    output logic                  point
);

    pong_pkg::game_state_t state_nxt;

    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            state <= pong_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // transitions
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        point     = 1'b0;
        // menu screen overrides everything
        if (screen_idle) begin
            state_nxt = pong_pkg::IDLE;
        end else begin
            case (state)
                pong_pkg::IDLE: begin
                    state_nxt = pong_pkg::START;
                end
                pong_pkg::START: begin
                    if (game_over) begin
                        state_nxt = pong_pkg::WIN;
                    end else if (serve) begin
                        state_nxt = pong_pkg::FLY;
                    end
                end
                pong_pkg::FLY: begin
                    if (miss) begin
                        state_nxt = pong_pkg::P_SCOR;
                    end
                end
                pong_pkg::P_SCOR: begin
                    // glide finished, hand out the point
                    if (at_edge) begin
                        state_nxt = pong_pkg::START;
                        point     = 1'b1;
                    end
                end
                pong_pkg::WIN: begin
                    if (serve) begin
                        state_nxt = pong_pkg::IDLE;
                    end
                end
                default: begin
                    state_nxt = pong_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/ball_motion.sv
// ball position register with per-frame stepping and screen edge detection
`timescale 1ns/1ps
`include "pong_defines.svh"

module ball_motion (
    input  logic                  clk65MHz,
    input  logic                  rst,
    input  pong_pkg::game_state_t state,
    input  logic                  end_of_frame,
    input  pong_pkg::flight_dir_t dir,
    output pong_pkg::ball_pos_t   ball,
    output logic                  at_edge
);

    localparam logic signed [10:0] STEP = 11'(`PONG_SPEED);

    pong_pkg::ball_pos_t ball_nxt;
    logic signed [10:0]  dx;
    logic signed [10:0]  dy;
    logic                step;

    // direction to signed step
    always_comb begin
        dx = '0;
        dy = '0;
        if (dir.sw || dir.w || dir.nw) begin
            dx = -STEP;
        end else if (dir.ne || dir.e || dir.se) begin
            dx = STEP;
        end
        if (dir.nw || dir.ne) begin
            dy = -STEP;
        end else if (dir.sw || dir.se) begin
            dy = STEP;
        end
    end

    assign at_edge = ball.x > `PONG_EDGE_HIGH || ball.x < `PONG_EDGE_LOW;

    // glide stops once the edge is reached
    assign step = end_of_frame
               && (state == pong_pkg::FLY || (state == pong_pkg::P_SCOR && !at_edge));

    //////////////////////////////////////////////////////////////////////
    // position update
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ball_nxt = ball;
        case (state)
            pong_pkg::IDLE, pong_pkg::START: begin
                ball_nxt.x = 11'(`PONG_CENTER_X);
                ball_nxt.y = 11'(`PONG_CENTER_Y);
            end
            pong_pkg::FLY, pong_pkg::P_SCOR: begin
                if (step) begin
                    ball_nxt.x = ball.x + dx;
                    ball_nxt.y = ball.y + dy;
                end
            end
            pong_pkg::WIN: begin
                ball_nxt.y = '0;
            end
            default: begin
                ball_nxt = ball;
            end
        endcase
    end

    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            ball.x <= 11'(`PONG_CENTER_X);
            ball.y <= 11'(`PONG_CENTER_Y);
        end else begin
            ball <= ball_nxt;
        end
    end

endmodule

// File: src/pong_defines.svh
// playfield geometry, ball speed, win score and serve thresholds for the pong controller
`ifndef PONG_DEFINES_SVH
`define PONG_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// ball and rackets
//////////////////////////////////////////////////////////////////////
`define PONG_BALL_SIZE       15
`define PONG_RACKET_LEN      80
`define PONG_LEFT_BOUNCE_X   100
// ball size still to be taken off
`define PONG_RIGHT_BOUNCE_X  913

//////////////////////////////////////////////////////////////////////
// walls, motion and glide stops
//////////////////////////////////////////////////////////////////////
`define PONG_WALL_TOP        51
`define PONG_WALL_BOTTOM     717
`define PONG_SPEED           10
`define PONG_EDGE_LOW        11
`define PONG_EDGE_HIGH       1012
`define PONG_CENTER_X        504
`define PONG_CENTER_Y        376

// game length
`define PONG_WIN_POINTS      10

// serve counter bounds for sw, nw, w, e, ne; anything above gives se
`define PONG_SERVE_T1        19
`define PONG_SERVE_T2        38
`define PONG_SERVE_T3        64
`define PONG_SERVE_T4        89
`define PONG_SERVE_T5        108

`endif

// File: src/pong_pkg.sv
// game state enum and the ball position, flight direction, score and racket types
package pong_pkg;

    //////////////////////////////////////////////////////////////////////
    // game sequencing
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE   = 3'b000,
        START  = 3'b001,
        FLY    = 3'b010,
        P_SCOR = 3'b011,
        WIN    = 3'b100
    } game_state_t;

    // top left corner of the ball in pixels
    typedef struct packed {
        logic [10:0] x;
        logic [10:0] y;
    } ball_pos_t;

    // one hot, all zero while the ball stands still
    typedef struct packed {
        logic sw;
        logic w;
        logic nw;
        logic ne;
        logic e;
        logic se;
    } flight_dir_t;

    // p1 guards the right side, p2 the left
    typedef struct packed {
        logic [3:0] p1;
        logic [3:0] p2;
    } score_t;

    // racket top y
    typedef logic [9:0] racket_pos_t;

endpackage

// File: src/score_keeper.sv
// point counters for both players, game over flag and winner code
`timescale 1ns/1ps
`include "pong_defines.svh"

module score_keeper (
    input  logic                  clk65MHz,
    input  logic                  rst,
    input  pong_pkg::game_state_t state,
    input  logic                  point,
    input  pong_pkg::flight_dir_t dir,
    output pong_pkg::score_t      score,
    output logic                  game_over,
    output logic [1:0]            who_won
);

    pong_pkg::score_t score_nxt;
    logic [1:0]       who_won_nxt;
    logic             heading_west;

    // the ball left through the side it was flying to
    assign heading_west = dir.sw || dir.w || dir.nw;

    assign game_over = score.p1 >= `PONG_WIN_POINTS || score.p2 >= `PONG_WIN_POINTS;

    always_comb begin
        score_nxt = score;
        if (state == pong_pkg::IDLE) begin
            score_nxt = '0;
        end else if (point) begin
            if (heading_west) begin
                score_nxt.p2 = score.p2 + 4'd1;
            end else begin
                score_nxt.p1 = score.p1 + 4'd1;
            end
        end
    end

    // 2 for player 1, 1 for player 2
    always_comb begin
        who_won_nxt = 2'd0;
        if (state == pong_pkg::WIN) begin
            who_won_nxt = (score.p1 > score.p2) ? 2'd2 : 2'd1;
        end
    end

    always_ff @(posedge clk65MHz) begin
        if (rst) begin
            score   <= '0;
            who_won <= 2'd0;
        end else begin
            score   <= score_nxt;
            who_won <= who_won_nxt;
        end
    end

endmodule

// File: verification/ball_control_tb.sv
// testbench for the pong ball controller: clocking, rally stimulus, assertions and error counts
`timescale 1ns/1ps
`include "pong_defines.svh"

module ball_control_tb;

    logic                  clk65MHz;
    logic                  rst;
    logic                  end_of_frame;
    logic                  serve;
    logic                  screen_idle;
    pong_pkg::racket_pos_t pos_of_player_1;
    pong_pkg::racket_pos_t pos_of_player_2;
    pong_pkg::ball_pos_t   ball;
    pong_pkg::score_t      score;
    logic [1:0]            who_won;

    int                  errors;
    int                  cyc;
    int                  last_dx;
    int                  reversals;
    int                  seed_val;
    bit                  timed_out;
    bit                  park_p1;
    bit                  park_p2;
    pong_pkg::ball_pos_t prev_ball;
    pong_pkg::score_t    old_score;
    pong_pkg::score_t    exp_score;

    ball_control i_dut (.*);

    initial begin
        clk65MHz = 1'b0;
        forever #20 clk65MHz = ~clk65MHz;
    end

    function automatic bit is_center(pong_pkg::ball_pos_t b);
        return b.x == `PONG_CENTER_X && b.y == `PONG_CENTER_Y;
    endfunction

    // one step of the ball, x always moves, y may stay
    function automatic bit step_ok(pong_pkg::ball_pos_t a, pong_pkg::ball_pos_t b);
        int                 dx;
        logic signed [10:0] dy;
        dx = int'(b.x) - int'(a.x);
        // y wraps when a glide leaves through the top
        dy = $signed(b.y - a.y);
        return (dx == `PONG_SPEED || dx == -`PONG_SPEED)
            && (dy == `PONG_SPEED || dy == 0 || dy == -`PONG_SPEED);
    endfunction

    // racket top somewhere that still covers the ball
    function automatic pong_pkg::racket_pos_t track_pos(logic [10:0] y);
        int top;
        top = int'(y) + 10 - int'($urandom_range(84, 0));
        if (top < 0) begin
            top = 0;
        end
        return pong_pkg::racket_pos_t'(top);
    endfunction

    // racket top well clear of the ball
    function automatic pong_pkg::racket_pos_t park_pos(logic [10:0] y);
        return (y >= 360) ? 10'd0 : 10'd700;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // input drivers and step monitor
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk65MHz) begin
        #2;
        cyc             = cyc + 1;
        end_of_frame    = (cyc % 8 == 0);
        pos_of_player_1 = park_p1 ? park_pos(ball.y) : track_pos(ball.y);
        pos_of_player_2 = park_p2 ? park_pos(ball.y) : track_pos(ball.y);
    end

    always @(posedge clk65MHz) begin
        int dx;
        dx = int'(ball.x) - int'(prev_ball.x);
        if (!rst && (dx == `PONG_SPEED || dx == -`PONG_SPEED)) begin
            if (last_dx != 0 && (dx > 0) != (last_dx > 0)) begin
                reversals = reversals + 1;
            end
            last_dx = dx;
        end
        prev_ball = ball;
    end

    //////////////////////////////////////////////////////////////////////
    // concurrent checks
    //////////////////////////////////////////////////////////////////////
    assert property (@(posedge clk65MHz) rst |=> (is_center(ball) && score == 0 && who_won == 0))
    else begin
        errors++;
        $display("Error %0t: ball, score or winner not cleared after reset", $time);
    end

    assert property (@(posedge clk65MHz) disable iff (rst)
        (screen_idle && $past(screen_idle)) |=> (is_center(ball) && score == 0 && who_won == 0))
    else begin
        errors++;
        $display("Error %0t: game not held idle by screen_idle", $time);
    end

    assert property (@(posedge clk65MHz) disable iff (rst)
        (ball != $past(ball) && !is_center(ball) && ball.y != 0)
        |-> ($past(end_of_frame) && step_ok($past(ball), ball)))
    else begin
        errors++;
        $display("Error %0t: bad ball step to (%0d, %0d)", $time, ball.x, ball.y);
    end

    assert property (@(posedge clk65MHz) disable iff (rst)
        (ball.x > `PONG_LEFT_BOUNCE_X && ball.x < `PONG_RIGHT_BOUNCE_X - `PONG_BALL_SIZE
            && who_won == 0)
        |-> (ball.y >= `PONG_WALL_TOP - `PONG_SPEED
            && ball.y <= `PONG_WALL_BOTTOM - `PONG_BALL_SIZE + `PONG_SPEED))
    else begin
        errors++;
        $display("Error %0t: ball y %0d outside the walls", $time, ball.y);
    end

    //////////////////////////////////////////////////////////////////////
    // sequencing helpers
    //////////////////////////////////////////////////////////////////////
    task automatic tick();
        @(posedge clk65MHz);
        #2;
    endtask

    task automatic pulse_serve();
        serve = 1'b1;
        tick();
        serve = 1'b0;
    endtask

    // 0 score change, 1 ball centred, 2 winner shown, 3 scores cleared
    task automatic wait_until(input int kind, input int limit, input string what);
        int n;
        bit done;
        n    = 0;
        done = 1'b0;
        while (!done && !timed_out) begin
            case (kind)
                0: done = (score != old_score);
                1: done = is_center(ball);
                2: done = (who_won != 0);
                default: done = (score == 0);
            endcase
            if (!done) begin
                n++;
                if (n > limit) begin
                    timed_out = 1'b1;
                    errors++;
                    $display("gave up waiting for %s at %0t", what, $time);
                end else begin
                    tick();
                end
            end
        end
    endtask

    // one rally that ends in a miss, credited by the last x heading
    task automatic play_point();
        pong_pkg::score_t expected;
        old_score = score;
        wait_until(0, 6000, "a point");
        expected = exp_score;
        if (last_dx < 0) begin
            expected.p2 = exp_score.p2 + 4'd1;
        end else begin
            expected.p1 = exp_score.p1 + 4'd1;
        end
        assert (timed_out || score == expected) else begin
            errors++;
            $display("Error %0t: score %h, expected %h", $time, score, expected);
        end
        exp_score = expected;
        wait_until(1, 20, "the ball back at the centre");
    endtask

    initial begin
        seed_val        = $urandom(32'h3e7d2bff);
        errors          = 0;
        cyc             = 0;
        last_dx         = 0;
        reversals       = 0;
        timed_out       = 1'b0;
        park_p1         = 1'b0;
        park_p2         = 1'b0;
        rst             = 1'b1;
        end_of_frame    = 1'b0;
        serve           = 1'b0;
        screen_idle     = 1'b0;
        pos_of_player_1 = '0;
        pos_of_player_2 = '0;
        old_score       = '0;
        exp_score       = '0;
        repeat (16) tick();
        rst         = 1'b0;
        screen_idle = 1'b1;
        repeat (6) tick();
        screen_idle = 1'b0;
        repeat (3) tick();

        // long rally with both rackets on the ball
        old_score = score;
        pulse_serve();
        repeat (8 * 200) tick();
        assert (score == old_score && reversals >= 2) else begin
            errors++;
            $display("Error %0t: rally gave %0d reversals, score %h", $time, reversals, score);
        end

        park_p1 = 1'b1;
        play_point();
        park_p1 = 1'b0;
        park_p2 = 1'b1;
        pulse_serve();
        play_point();

        // both parked until someone wins
        park_p1 = 1'b1;
        for (int i = 0; i < 20 && !timed_out; i++) begin
            if (exp_score.p1 < `PONG_WIN_POINTS && exp_score.p2 < `PONG_WIN_POINTS) begin
                pulse_serve();
                play_point();
            end
        end
        wait_until(2, 20, "the win screen");
        assert (timed_out || (ball.y == 0
            && who_won == ((exp_score.p1 >= `PONG_WIN_POINTS) ? 2'd2 : 2'd1)))
        else begin
            errors++;
            $display("Error %0t: win screen y %0d winner %0d", $time, ball.y, who_won);
        end
        pulse_serve();
        wait_until(3, 20, "the scores to clear");
        exp_score = '0;

        // menu screen in the middle of a rally
        park_p1 = 1'b0;
        park_p2 = 1'b0;
        repeat (3) tick();
        pulse_serve();
        repeat (40) tick();
        screen_idle = 1'b1;
        repeat (4) tick();
        screen_idle = 1'b0;
        repeat (4) tick();

        $display("run finished with %0d errors, %0d timeouts", errors, timed_out);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
